/* run.sh */
#!/bin/sh
# Compile the egress scheduler testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module egr_sched_tb -o egr_sched_sim

# The simulation result is taken from the log, not from the exit code
./obj_dir/egr_sched_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* src.f */
verilog/egr_sched_pkg.sv
verilog/egr_desc_queue.sv
verilog/egr_fair_drr_arb.sv
verilog/egr_sched_dispatch.sv
verilog/egr_sched_top.sv
tb/tb_clkgen.sv
tb/egr_sched_tb.sv

/* tb/egr_sched_tb.sv */
// Testbench for the egress scheduler with a cycle model of queues and credit counters
// The model state is advanced on the falling edge and matches the DUT after the next rise
// Inputs change 1 ns after each rising edge and outputs are compared on the falling edge
// Only one descriptor enters per cycle and one leaves per cycle, so no queue can fill
`timescale 1ns/1ps

module egr_sched_tb;

    import egr_sched_pkg::*;

    localparam int NUM_QUEUES    = 4;
    localparam int QUEUE_DEPTH   = 8;
    localparam int CTR_W         = $clog2(MAX_LATENCY * MAX_COST);
    localparam int RESET_CYCLES  = 8;
    localparam int QUIET_CYCLES  = 6;
    localparam int SINGLE_PKTS   = 6;
    localparam int EQUAL_PKTS    = 12;
    localparam int RANDOM_CYCLES = 200;
    localparam int REFILL_PKTS   = 6;
    localparam int DRAIN_CYCLES  = 10;

    // Every stimulus cycle of every test, idle gaps included
    localparam int STIM_CYCLES = QUIET_CYCLES + SINGLE_PKTS + EQUAL_PKTS + RANDOM_CYCLES
        + 2 * REFILL_PKTS + QUEUE_DEPTH + 6 * DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + 50;

    logic                  clk;
    logic                  reset;
    logic                  enq;
    logic [QID_W-1:0]      enq_qid;
    pkt_desc_t             enq_desc;
    logic                  out_valid;
    sched_out_t            out;
    logic [NUM_QUEUES-1:0] full;

    // ------------------------------------------------------------
    // Model state
    // ------------------------------------------------------------

    pkt_desc_t                        mq [NUM_QUEUES][$];
    logic [NUM_QUEUES-1:0][CTR_W-1:0] m_ctr;
    logic [NUM_QUEUES-1:0]            m_consume;
    logic [COST_W-1:0]                m_cost;
    logic                             exp_valid;
    sched_out_t                       exp_out;

    string          test_name;
    int             mismatch_errors;
    int             other_errors;
    int             seed;
    int             tag_seen [256];
    logic [TAG_W-1:0] next_tag;

    tb_clkgen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clkgen (
        .clk   (clk),
        .reset (reset)
    );

    egr_sched_top #(
        .NUM_QUEUES  (NUM_QUEUES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .enq       (enq),
        .enq_qid   (enq_qid),
        .enq_desc  (enq_desc),
        .out_valid (out_valid),
        .out       (out),
        .full      (full)
    );

    // ------------------------------------------------------------
    // Reference functions
    // ------------------------------------------------------------

    // Highest bit of the OR over requesting counters, then the lowest queue holding it
    // With no credit anywhere the lowest requesting queue wins
    function automatic int pick_winner(input logic [NUM_QUEUES-1:0] req,
                                       input logic [NUM_QUEUES-1:0][CTR_W-1:0] ctr);
        logic [CTR_W-1:0] merged;
        int               top;
        int               winner;
        merged = '0;
        top    = -1;
        winner = -1;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            if (req[i]) begin
                merged |= ctr[i];
            end
        end
        for (int b = 0; b < CTR_W; b++) begin
            if (merged[b]) begin
                top = b;
            end
        end
        for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
            if (req[i] && (top < 0 || ctr[i][top])) begin
                winner = i;
            end
        end
        return winner;
    endfunction

    // Shortfall of the returned cost above the AND of the consumed counters
    function automatic logic [CTR_W-1:0] top_up(input logic [NUM_QUEUES-1:0] consume,
                                                input logic [NUM_QUEUES-1:0][CTR_W-1:0] ctr,
                                                input logic [CTR_W-1:0] cost);
        logic [CTR_W-1:0] and_val;
        and_val = '1;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            if (consume[i]) begin
                and_val &= ctr[i];
            end
        end
        return (cost > and_val) ? cost - and_val : '0;
    endfunction

    // One counter's next value, wrapping at the counter width
    function automatic logic [CTR_W-1:0] next_credit(input logic [CTR_W-1:0] ctr,
                                                     input logic req,
                                                     input logic popped,
                                                     input logic consumed,
                                                     input logic [CTR_W-1:0] topup,
                                                     input logic [CTR_W-1:0] cost);
        logic [CTR_W-1:0] max_cost;
        max_cost = CTR_W'(MAX_COST);
        if (!req) begin
            return '0;
        end
        if (popped && consumed) begin
            return ctr + topup - cost;
        end
        if (popped) begin
            return ctr + topup - max_cost;
        end
        if (consumed) begin
            return ctr + max_cost - cost;
        end
        return ctr;
    endfunction

    // ------------------------------------------------------------
    // Compare and advance the model
    // ------------------------------------------------------------

    always @(negedge clk) begin : compare_and_step
        logic [NUM_QUEUES-1:0] req;
        logic [NUM_QUEUES-1:0] m_full;
        logic [CTR_W-1:0]      topup;
        logic [CTR_W-1:0]      cost_ext;
        pkt_desc_t             head;
        int                    w;
        if (reset) begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                mq[i].delete();
            end
            m_ctr     = '0;
            m_consume = '0;
            m_cost    = '0;
            exp_valid = 1'b0;
        end else begin
            for (int i = 0; i < NUM_QUEUES; i++) begin
                req[i]    = (mq[i].size() != 0);
                m_full[i] = (mq[i].size() == QUEUE_DEPTH);
            end
            assert (out_valid === exp_valid) else begin
                mismatch_errors++;
                $display("mismatch in %s: out_valid expected %0b, actual %0b",
                         test_name, exp_valid, out_valid);
            end
            if (exp_valid && out_valid) begin
                assert (out === exp_out) else begin
                    mismatch_errors++;
                    $display("mismatch in %s: out expected %h, actual %h",
                             test_name, exp_out, out);
                end
            end
            assert (full === m_full) else begin
                mismatch_errors++;
                $display("mismatch in %s: full expected %b, actual %b", test_name, m_full, full);
            end
            if (out_valid) begin
                tag_seen[out.desc.tag]++;
            end
            // The grant of this cycle is the launch and the consume of the next one
            w        = pick_winner(req, m_ctr);
            cost_ext = CTR_W'(m_cost);
            topup    = top_up(m_consume, m_ctr, cost_ext);
            for (int i = 0; i < NUM_QUEUES; i++) begin
                m_ctr[i] = next_credit(m_ctr[i], req[i], w == i, m_consume[i], topup, cost_ext);
            end
            m_consume = '0;
            m_cost    = '0;
            exp_valid = (w >= 0);
            if (w >= 0) begin
                head         = mq[w].pop_front();
                exp_out.qid  = QID_W'(w);
                exp_out.desc = head;
                m_consume[w] = 1'b1;
                m_cost       = head.cost;
            end
            if (enq) begin
                mq[int'(enq_qid)].push_back(enq_desc);
            end
        end
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic enqueue(input int qid, input int cost);
        enq           = 1'b1;
        enq_qid       = QID_W'(qid);
        enq_desc.cost = COST_W'(cost);
        enq_desc.tag  = next_tag;
        next_tag++;
        next_cycle();
        enq = 1'b0;
    endtask

    task automatic idle(input int cycles);
        enq = 1'b0;
        repeat (cycles) next_cycle();
    endtask

    // Stops the run if the tests overrun their cycle budget
    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        other_errors++;
        $display("Watchdog expired after %0d cycles with the tests still running",
                 WATCHDOG_CYCLES);
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        $display("Test failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0]      rnd;
        logic [TAG_W-1:0] first_tag;
        int               n_sent;
        int               qsel;
        enq             = 1'b0;
        enq_qid         = '0;
        enq_desc        = '0;
        mismatch_errors = 0;
        other_errors    = 0;
        next_tag        = '0;
        seed            = 32'hf283_b0c5;
        test_name       = "reset";
        for (int t = 0; t < 256; t++) begin
            tag_seen[t] = 0;
        end
        @(negedge reset);
        #1;

        test_name = "reset quiet";
        idle(QUIET_CYCLES);
        assert (full == '0) else begin
            mismatch_errors++;
            $display("mismatch in %s: full expected 0, actual %b", test_name, full);
        end

        // FIFO order and timing out of one queue
        test_name = "single queue";
        for (int k = 0; k < SINGLE_PKTS; k++) begin
            enqueue(1, 3 + 7 * k);
        end
        idle(DRAIN_CYCLES);

        test_name = "equal cost";
        for (int k = 0; k < EQUAL_PKTS; k++) begin
            enqueue((k % 2) * 2, 20);
        end
        idle(DRAIN_CYCLES);

        test_name = "unequal random costs";
        first_tag = next_tag;
        n_sent    = 0;
        for (int t = 0; t < 256; t++) begin
            tag_seen[t] = 0;
        end
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            rnd  = $random(seed);
            qsel = int'(rnd[15:8] % NUM_QUEUES);
            if (rnd[0] && mq[qsel].size() < QUEUE_DEPTH) begin
                enqueue(qsel, int'(rnd[31:16] % (MAX_COST - 1)) + 1);
                n_sent++;
            end else begin
                idle(1);
            end
        end
        idle(DRAIN_CYCLES);
        for (int k = 0; k < n_sent; k++) begin
            assert (tag_seen[first_tag + TAG_W'(k)] == 1) else begin
                mismatch_errors++;
                $display("mismatch in %s: launches of tag %h expected 1, actual %0d",
                         test_name, first_tag + TAG_W'(k), tag_seen[first_tag + TAG_W'(k)]);
            end
        end

        // Queue 3 runs dry between the two bursts, which clears its credit
        test_name = "drain and refill";
        for (int k = 0; k < REFILL_PKTS; k++) begin
            enqueue((k % 2 == 0) ? 3 : 1, 10 + 9 * k);
        end
        idle(DRAIN_CYCLES);
        for (int k = 0; k < REFILL_PKTS; k++) begin
            enqueue((k % 2 == 0) ? 3 : 1, 50 - 8 * k);
        end
        idle(DRAIN_CYCLES);

        // Back to back pushes into one queue, with full followed against the model
        test_name = "full flag";
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            enqueue(2, 5);
        end
        idle(DRAIN_CYCLES);

        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb/tb_clkgen.sv */
// Clock and reset source for the scheduler testbench
// The clock starts low, so the first rising edge comes half a period in
// Reset is high from time zero and drops 1 ns after the last reset edge
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands in the same slot as the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* verilog/egr_desc_queue.sv */
// Single descriptor FIFO with a combinational head
// DEPTH must be a power of two so the pointers wrap on their own
// Push and pop may share a cycle. A push into a full queue is legal only
// together with a pop
`timescale 1ns/1ps

module egr_desc_queue #(
    parameter int DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  egr_sched_pkg::pkt_desc_t push_desc,
    input  logic                     pop,
    output egr_sched_pkg::pkt_desc_t head,
    output logic                     empty,
    output logic                     full
);

    import egr_sched_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // ------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------

    // Descriptor storage holds payload only and is never cleared
    pkt_desc_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Writes land at the write pointer on the edge of the push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_desc;
        end
    end

    // Pointers advance independently and the count tracks the difference
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Status and head
    // ------------------------------------------------------------

    // Both flags come from the registered count, so a push is seen one cycle later
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // The head is read in the same cycle as the pop that removes it
    assign head = mem[rd_ptr];

    // An overflow would overwrite the oldest descriptor
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        (push && full) |-> pop);

    // Dispatch must only pop a queue that reported a request
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

/* verilog/egr_fair_drr_arb.sv */
// Deficit round robin arbiter over WIDTH requesters
// win is combinational on arb and the credit counters, with no registered stage
// The cost of a grant comes back later on consume and cost, one-hot, at most
// MAX_LATENCY grants ahead. Counters wrap at their width by design
// A requester that drops its request loses all of its credit
`timescale 1ns/1ps

module egr_fair_drr_arb #(
    parameter int WIDTH       = 4,
    parameter int MAX_LATENCY = egr_sched_pkg::MAX_LATENCY
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [WIDTH-1:0]                 arb,
    output logic [WIDTH-1:0]                 win,
    input  logic                             pop,
    input  logic [WIDTH-1:0]                 consume,
    input  logic [egr_sched_pkg::COST_W-1:0] cost
);

    import egr_sched_pkg::*;

    localparam int CTR_W = $clog2(MAX_LATENCY * MAX_COST);
    localparam logic [CTR_W-1:0] MAX_COST_C = CTR_W'(MAX_COST);

    // Per-requester credit counters
    logic [WIDTH-1:0][CTR_W-1:0] ctr;

    logic [CTR_W-1:0] all_ctr;
    logic [CTR_W-1:0] all_ctr_rev;
    logic [CTR_W-1:0] top_bit_rev;
    logic [CTR_W-1:0] top_bit;
    logic [CTR_W-1:0] chosen_ctr;
    logic [CTR_W-1:0] cost_ext;
    logic [CTR_W-1:0] global_inc;
    logic [WIDTH-1:0] has_top;
    logic [WIDTH-1:0] cand;

    // ------------------------------------------------------------
    // Win selection
    // ------------------------------------------------------------

    // Merge the counters of everyone asking this cycle
    always_comb begin
        all_ctr = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (arb[i]) begin
                all_ctr |= ctr[i];
            end
        end
    end

    // Reverse, isolate the lowest set bit and reverse back
    // This yields the highest set bit of the merged counters
    always_comb begin
        for (int i = 0; i < CTR_W; i++) begin
            all_ctr_rev[i] = all_ctr[CTR_W-1-i];
        end
    end

    assign top_bit_rev = all_ctr_rev & (~all_ctr_rev + 1'b1);

    always_comb begin
        for (int i = 0; i < CTR_W; i++) begin
            top_bit[i] = top_bit_rev[CTR_W-1-i];
        end
    end

    // With no credit anywhere every requester ties
    // Otherwise only counters holding the top bit qualify
    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            has_top[i] = (top_bit == '0) || (|(top_bit & ctr[i]));
        end
    end

    // Lowest index among the qualifying requesters wins
    assign cand = arb & has_top;
    assign win  = cand & (~cand + 1'b1);

    // ------------------------------------------------------------
    // Counter update
    // ------------------------------------------------------------

    // AND of the consumed counters, all ones when nothing is consumed
    always_comb begin
        chosen_ctr = '1;
        for (int i = 0; i < WIDTH; i++) begin
            if (consume[i]) begin
                chosen_ctr &= ctr[i];
            end
        end
    end

    assign cost_ext = {{(CTR_W - COST_W){1'b0}}, cost};

    // Top-up is the shortfall of the returned cost above that value
    assign global_inc = (chosen_ctr >= cost_ext) ? '0 : (cost_ext - chosen_ctr);

    // A grant charges MAX_COST up front and the consume refunds the unused part
    always_ff @(posedge clk) begin
        for (int i = 0; i < WIDTH; i++) begin
            if (reset || !arb[i]) begin
                ctr[i] <= '0;
            end else begin
                case ({consume[i], win[i] & pop})
                    2'b01:   ctr[i] <= ctr[i] + global_inc - MAX_COST_C;
                    2'b10:   ctr[i] <= ctr[i] + MAX_COST_C - cost_ext;
                    2'b11:   ctr[i] <= ctr[i] + global_inc - cost_ext;
                    default: ctr[i] <= ctr[i];
                endcase
            end
        end
    end

    // Some requester always holds the top bit, so no request is left without a grant
    a_win_when_arb: assert property (@(posedge clk) disable iff (reset)
        (arb != '0) |-> (win != '0));

    // The returned cost belongs to exactly one earlier grant
    a_consume_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(consume));

endmodule

/* verilog/egr_sched_dispatch.sv */
// Dispatch stage between the arbiter and the output
// Pops the granted queue in the grant cycle and launches its head one cycle later
// The consume for a launch is returned in the launch cycle, so at most one
// cost is outstanding toward the arbiter
// NUM_QUEUES must not exceed 256 because of the queue index width
`timescale 1ns/1ps

module egr_sched_dispatch #(
    parameter int NUM_QUEUES = 4
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [NUM_QUEUES-1:0]            win,
    input  egr_sched_pkg::pkt_desc_t         heads [NUM_QUEUES],
    output logic                             pop,
    output logic [NUM_QUEUES-1:0]            q_pop,
    output logic                             out_valid,
    output egr_sched_pkg::sched_out_t        out,
    output logic [NUM_QUEUES-1:0]            consume,
    output logic [egr_sched_pkg::COST_W-1:0] cost
);

    import egr_sched_pkg::*;

    pkt_desc_t             sel_desc;
    logic [QID_W-1:0]      sel_qid;
    logic [NUM_QUEUES-1:0] win_q;

    // ------------------------------------------------------------
    // Grant cycle
    // ------------------------------------------------------------

    // Every grant is taken, since the output never stalls
    assign pop   = |win;
    assign q_pop = win;

    // The grant is one-hot, so an OR of the masked heads selects the winner
    always_comb begin
        sel_desc = '0;
        sel_qid  = '0;
        for (int i = 0; i < NUM_QUEUES; i++) begin
            if (win[i]) begin
                sel_desc |= heads[i];
                sel_qid  |= QID_W'(i);
            end
        end
    end

    // ------------------------------------------------------------
    // Launch cycle
    // ------------------------------------------------------------

    // Control flops
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            win_q     <= '0;
        end else begin
            out_valid <= pop;
            win_q     <= win;
        end
    end

    // The launched descriptor is payload and is only loaded on a grant
    always_ff @(posedge clk) begin
        if (pop) begin
            out.qid  <= sel_qid;
            out.desc <= sel_desc;
        end
    end

    // Consume follows the launch and names the queue that was charged
    assign consume = win_q;

    // Cost is held at zero between launches so stale payload never reaches the counters
    assign cost = out_valid ? out.desc.cost : '0;

    // A launch returns its cost in the same cycle to the queue it came from
    a_launch_consumes: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (consume == (NUM_QUEUES'(1) << out.qid)));

endmodule

/* verilog/egr_sched_pkg.sv */
// Shared widths, constants and descriptor types for the egress scheduler
// The cost field width follows MAX_COST, so the cost range is 1 to MAX_COST-1
// A cost of zero is not a legal descriptor cost
// The queue index in the output is 8 bits, which limits the design to 256 queues
package egr_sched_pkg;

    // ------------------------------------------------------------
    // Cost and credit sizing
    // ------------------------------------------------------------

    // One more than the largest descriptor cost
    localparam int MAX_COST = 64;

    // Bits needed to carry any legal cost
    localparam int COST_W = $clog2(MAX_COST);

    // Launches that may be in flight before their consume returns
    // The arbiter sizes its credit counters from this and MAX_COST
    localparam int MAX_LATENCY = 4;

    // ------------------------------------------------------------
    // Descriptor fields
    // ------------------------------------------------------------

    // The tag is carried through untouched
    localparam int TAG_W = 8;

    // Width of the queue index reported with each launch
    localparam int QID_W = 8;

    // One packet descriptor as stored in a queue
    typedef struct packed {
        logic [COST_W-1:0] cost;
        logic [TAG_W-1:0]  tag;
    } pkt_desc_t;

    // One launched descriptor together with the queue it came from
    typedef struct packed {
        logic [QID_W-1:0] qid;
        pkt_desc_t        desc;
    } sched_out_t;

endpackage

/* verilog/egr_sched_top.sv */
// Egress scheduler top level
// Enqueue has no back-pressure, so the user must watch the full flags
// A queue index at or above NUM_QUEUES and a cost of zero are illegal
// QUEUE_DEPTH must be a power of two and NUM_QUEUES at most 256
`timescale 1ns/1ps

module egr_sched_top #(
    parameter int NUM_QUEUES  = 4,
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            enq,
    input  logic [egr_sched_pkg::QID_W-1:0] enq_qid,
    input  egr_sched_pkg::pkt_desc_t        enq_desc,
    output logic                            out_valid,
    output egr_sched_pkg::sched_out_t       out,
    output logic [NUM_QUEUES-1:0]           full
);

    import egr_sched_pkg::*;

    logic [NUM_QUEUES-1:0] q_push;
    logic [NUM_QUEUES-1:0] q_pop;
    logic [NUM_QUEUES-1:0] q_empty;
    logic [NUM_QUEUES-1:0] req;
    logic [NUM_QUEUES-1:0] win;
    logic [NUM_QUEUES-1:0] consume;
    logic [COST_W-1:0]     cost;
    logic                  pop;
    pkt_desc_t             heads [NUM_QUEUES];

    // ------------------------------------------------------------
    // Queue array
    // ------------------------------------------------------------

    for (genvar g = 0; g < NUM_QUEUES; g++) begin : g_queue
        // Enqueue decode for this queue
        assign q_push[g] = enq && (enq_qid == QID_W'(g));

        egr_desc_queue #(
            .DEPTH (QUEUE_DEPTH)
        ) u_queue (
            .clk       (clk),
            .reset     (reset),
            .push      (q_push[g]),
            .push_desc (enq_desc),
            .pop       (q_pop[g]),
            .head      (heads[g]),
            .empty     (q_empty[g]),
            .full      (full[g])
        );
    end

    // A queue requests whenever it holds anything
    assign req = ~q_empty;

    // ------------------------------------------------------------
    // Arbitration and dispatch
    // ------------------------------------------------------------

    egr_fair_drr_arb #(
        .WIDTH       (NUM_QUEUES),
        .MAX_LATENCY (MAX_LATENCY)
    ) u_arb (
        .clk     (clk),
        .reset   (reset),
        .arb     (req),
        .win     (win),
        .pop     (pop),
        .consume (consume),
        .cost    (cost)
    );

    egr_sched_dispatch #(
        .NUM_QUEUES (NUM_QUEUES)
    ) u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .win       (win),
        .heads     (heads),
        .pop       (pop),
        .q_pop     (q_pop),
        .out_valid (out_valid),
        .out       (out),
        .consume   (consume),
        .cost      (cost)
    );

    // An out of range index would silently drop the descriptor
    a_enq_qid_range: assert property (@(posedge clk) disable iff (reset)
        enq |-> (enq_qid < QID_W'(NUM_QUEUES)));

    // A zero cost would let a queue send without ever spending credit
    a_enq_cost_nonzero: assert property (@(posedge clk) disable iff (reset)
        enq |-> (enq_desc.cost != '0));

endmodule
